// ==== design/mips_pkg.sv ====
/* mips pipeline package
   widths, instruction codes and pipeline register layouts */
package mips_pkg;

    typedef logic [31:0] word_t;     // data, address and instruction
    typedef logic [4:0]  reg_addr_t; // register index

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    localparam word_t RESET_PC = 32'h0040_0000; // first fetch address

    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;  // load data goes to the register file
        logic alu_src_imm; // second alu operand is the immediate
        logic reg_dst_rd;  // write rd, else rt
        logic branch_ne;
        logic is_rtype;    // alu op comes from funct
    } ctrl_t;

    typedef struct packed {
        ctrl_t      ctrl;
        logic [5:0] funct;
        word_t      rs_val;
        word_t      rt_val;
        word_t      imm;
        reg_addr_t  dest;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t dest;
        word_t     data;
    } wb_t;

endpackage

// ==== design/fetch_stage.sv ====
/* fetch stage
   program counter, next-pc selection and instruction memory with a load port */
`timescale 1ns/1ps

module fetch_stage #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                          SYS_clk,
    input  logic                          SYS_reset,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr,
    input  mips_pkg::word_t               prog_data,
    input  logic                          stall,
    input  logic                          redirect,
    input  mips_pkg::word_t               target,
    output mips_pkg::word_t               instr,
    output mips_pkg::word_t               pc
);
    import mips_pkg::*;

    localparam int IADDR_W = $clog2(IMEM_WORDS);

    word_t imem [IMEM_WORDS];
    word_t pc_offset;
    word_t pc_next;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset && prog_we)
            imem[prog_addr] <= prog_data; // program load only while reset is held
    end

    assign pc_offset = pc - RESET_PC;
    assign instr     = imem[pc_offset[IADDR_W+1:2]]; // word index from the reset pc

    always_comb
    begin
        if (stall)
            pc_next = pc;        // hold
        else if (redirect)
            pc_next = target;    // taken branch or jump from decode
        else
            pc_next = pc + 32'd4;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            pc <= RESET_PC;
        else
            pc <= pc_next;
    end

endmodule

// ==== design/hazard_unit.sv ====
/* hazard unit
   stall counter for producers still in flight, and decode forwarding selects */
`timescale 1ns/1ps

module hazard_unit (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    input  logic                uses_rs,
    input  logic                uses_rt,
    input  mips_pkg::reg_addr_t ex_dest,
    input  logic                ex_reg_write,
    input  logic                ex_mem_read,
    input  mips_pkg::reg_addr_t mem_dest,
    input  logic                mem_reg_write,
    input  logic                mem_mem_read,
    output logic                stall,
    output logic                fwd_rs,
    output logic                fwd_rt
);
    import mips_pkg::*;

    logic [1:0] stall_cnt;  // stall cycles left after the current one
    logic [1:0] stall_load; // stall length asked for by a new hazard
    logic       ex_hit;
    logic       mem_hit_rs;
    logic       mem_hit_rt;

    function automatic logic src_match(reg_addr_t dest, reg_addr_t src, logic used);
        return used && (dest != '0) && (dest == src);
    endfunction

    assign ex_hit     = ex_reg_write &&
                        (src_match(ex_dest, rs, uses_rs) || src_match(ex_dest, rt, uses_rt));
    assign mem_hit_rs = mem_reg_write && src_match(mem_dest, rs, uses_rs);
    assign mem_hit_rt = mem_reg_write && src_match(mem_dest, rt, uses_rt);

    always_comb
    begin
        stall_load = 2'd0;
        if (ex_hit)
            stall_load = ex_mem_read ? 2'd2 : 2'd1;  // load needs its data back from wb
        else if (mem_mem_read && (mem_hit_rs || mem_hit_rt))
            stall_load = 2'd1;                       // load one stage ahead
    end

    // a running count wins over any new match
    assign stall = (stall_cnt != 2'd0) || (stall_load != 2'd0);

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            stall_cnt <= 2'd0;
        else if (stall_cnt != 2'd0)
            stall_cnt <= stall_cnt - 2'd1;
        else if (stall_load != 2'd0)
            stall_cnt <= stall_load - 2'd1; // this cycle is the first stall
    end

    // alu result in memory goes straight to decode
    assign fwd_rs = !stall && !mem_mem_read && mem_hit_rs;
    assign fwd_rt = !stall && !mem_mem_read && mem_hit_rt;

endmodule

// ==== design/reg_file.sv ====
/* register file
   32 words, two read ports plus a debug port, write data bypassed to reads */
`timescale 1ns/1ps

module reg_file (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::wb_t       wb,
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    input  mips_pkg::reg_addr_t dbg_addr,
    output mips_pkg::word_t     rs_val,
    output mips_pkg::word_t     rt_val,
    output mips_pkg::word_t     dbg_val
);
    import mips_pkg::*;

    word_t regs [32];

    function automatic word_t read_port(reg_addr_t addr);
        if (wb.reg_write && (addr != '0) && (addr == wb.dest))
            return wb.data; // same-cycle write-through
        return regs[addr];
    endfunction

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb.reg_write && (wb.dest != '0))
            regs[wb.dest] <= wb.data; // $0 stays zero
    end

    always_comb
    begin
        rs_val  = read_port(rs);
        rt_val  = read_port(rt);
        dbg_val = read_port(dbg_addr);
    end

endmodule

// ==== design/decode_stage.sv ====
/* decode stage
   fetch/decode register, control decode, operand select and early branch resolve */
`timescale 1ns/1ps

module decode_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::word_t     instr,
    input  mips_pkg::word_t     pc,
    input  logic                stall,
    input  logic                fwd_rs,
    input  logic                fwd_rt,
    input  mips_pkg::word_t     mem_alu_result,
    input  mips_pkg::wb_t       wb,
    input  mips_pkg::reg_addr_t dbg_reg_addr,
    output mips_pkg::word_t     dbg_reg_data,
    output mips_pkg::reg_addr_t rs,
    output mips_pkg::reg_addr_t rt,
    output logic                uses_rs,
    output logic                uses_rt,
    output logic                redirect,
    output mips_pkg::word_t     target,
    output mips_pkg::id_ex_t    id_ex
);
    import mips_pkg::*;

    word_t   fd_instr;
    word_t   fd_pc;
    opcode_e opcode;
    ctrl_t   ctrl;
    logic    is_branch;
    logic    is_jump;
    word_t   imm;
    word_t   pc_plus4;
    word_t   rf_rs_val;
    word_t   rf_rt_val;
    word_t   rs_val;
    word_t   rt_val;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            fd_instr <= '0;
            fd_pc    <= '0;
        end
        else if (!stall)
        begin
            fd_instr <= redirect ? '0 : instr; // squash the slot behind a taken branch
            fd_pc    <= pc;
        end
    end

    assign opcode = opcode_e'(fd_instr[31:26]);
    assign rs     = fd_instr[25:21];
    assign rt     = fd_instr[20:16];

    always_comb
    begin
        ctrl      = '0;
        uses_rs   = 1'b0;
        uses_rt   = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        case (opcode)
            OP_RTYPE:
            begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst_rd = 1'b1;
                ctrl.is_rtype   = 1'b1;
                uses_rs         = 1'b1;
                uses_rt         = 1'b1;
            end
            OP_ADDI:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                uses_rs          = 1'b1;
            end
            OP_LW:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                uses_rs          = 1'b1;
            end
            OP_SW:
            begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                uses_rs          = 1'b1;
                uses_rt          = 1'b1; // store data
            end
            OP_BEQ, OP_BNE:
            begin
                ctrl.branch_ne = (opcode == OP_BNE);
                is_branch      = 1'b1;
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
            end
            OP_J:
                is_jump = 1'b1;
            default: ; // unsupported opcode runs as a nop
        endcase
    end

    reg_file u_reg_file (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .wb        (wb),
        .rs        (rs),
        .rt        (rt),
        .dbg_addr  (dbg_reg_addr),
        .rs_val    (rf_rs_val),
        .rt_val    (rf_rt_val),
        .dbg_val   (dbg_reg_data)
    );

    assign rs_val = fwd_rs ? mem_alu_result : rf_rs_val;
    assign rt_val = fwd_rt ? mem_alu_result : rf_rt_val;

    assign imm      = {{16{fd_instr[15]}}, fd_instr[15:0]};
    assign pc_plus4 = fd_pc + 32'd4;
    assign target   = is_jump ? {pc_plus4[31:28], fd_instr[25:0], 2'b00}
                              : pc_plus4 + {imm[29:0], 2'b00};

    // compare is only valid once the hazard unit releases the stall
    assign redirect = !stall &&
                      (is_jump || (is_branch && ((rs_val == rt_val) ^ ctrl.branch_ne)));

    always_comb
    begin
        id_ex.ctrl   = ctrl;
        id_ex.funct  = fd_instr[5:0];
        id_ex.rs_val = rs_val;
        id_ex.rt_val = rt_val;
        id_ex.imm    = imm;
        id_ex.dest   = ctrl.reg_dst_rd ? fd_instr[15:11] : rt;
    end

endmodule

// ==== design/execute_stage.sv ====
/* execute stage
   decode/execute register, alu operation decode and alu */
`timescale 1ns/1ps

module execute_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                stall,
    input  mips_pkg::id_ex_t    id_ex,
    output mips_pkg::ex_mem_t   ex_mem,
    output mips_pkg::reg_addr_t ex_dest,
    output logic                ex_reg_write,
    output logic                ex_mem_read
);
    import mips_pkg::*;

    id_ex_t  ex_q;
    alu_op_e alu_op;
    word_t   alu_b;
    word_t   alu_result;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)
            ex_q <= '0; // bubble while decode is held
        else
            ex_q <= id_ex;
    end

    always_comb
    begin
        alu_op = ALU_ADD; // lw, sw and addi form an address or a sum
        if (ex_q.ctrl.is_rtype)
        begin
            case (funct_e'(ex_q.funct))
                FN_SUB:  alu_op = ALU_SUB;
                FN_AND:  alu_op = ALU_AND;
                FN_OR:   alu_op = ALU_OR;
                FN_SLT:  alu_op = ALU_SLT;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    assign alu_b = ex_q.ctrl.alu_src_imm ? ex_q.imm : ex_q.rt_val;

    always_comb
    begin
        case (alu_op)
            ALU_SUB: alu_result = ex_q.rs_val - alu_b;
            ALU_AND: alu_result = ex_q.rs_val & alu_b;
            ALU_OR:  alu_result = ex_q.rs_val | alu_b;
            ALU_SLT: alu_result = {31'd0, $signed(ex_q.rs_val) < $signed(alu_b)};
            default: alu_result = ex_q.rs_val + alu_b;
        endcase
    end

    always_comb
    begin
        ex_mem.ctrl       = ex_q.ctrl;
        ex_mem.alu_result = alu_result;
        ex_mem.store_data = ex_q.rt_val;
        ex_mem.dest       = ex_q.dest;
    end

    assign ex_dest      = ex_q.dest;
    assign ex_reg_write = ex_q.ctrl.reg_write;
    assign ex_mem_read  = ex_q.ctrl.mem_read;

endmodule

// ==== design/mem_wb_stage.sv ====
/* memory and writeback stages
   data memory access, then the write request back to the register file */
`timescale 1ns/1ps

module mem_wb_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::ex_mem_t   ex_mem,
    output mips_pkg::reg_addr_t mem_dest,
    output logic                mem_reg_write,
    output logic                mem_mem_read,
    output mips_pkg::word_t     mem_alu_result,
    output mips_pkg::wb_t       wb
);
    import mips_pkg::*;

    localparam int DADDR_W = $clog2(DMEM_WORDS);

    ex_mem_t            mem_q;
    word_t              dmem [DMEM_WORDS];
    logic [DADDR_W-1:0] dmem_idx;
    word_t              load_data;
    logic               wb_reg_write;
    logic               wb_mem_to_reg;
    reg_addr_t          wb_dest;
    word_t              wb_alu;
    word_t              wb_load;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            mem_q <= '0;
        else
            mem_q <= ex_mem;
    end

    assign dmem_idx  = mem_q.alu_result[DADDR_W+1:2]; // word addressed
    assign load_data = dmem[dmem_idx];

    always_ff @(posedge SYS_clk)
    begin
        if (mem_q.ctrl.mem_write)
            dmem[dmem_idx] <= mem_q.store_data;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_reg_write  <= 1'b0;
            wb_mem_to_reg <= 1'b0;
        end
        else
        begin
            wb_reg_write  <= mem_q.ctrl.reg_write;
            wb_mem_to_reg <= mem_q.ctrl.mem_to_reg;
        end
        wb_dest <= mem_q.dest;
        wb_alu  <= mem_q.alu_result;
        wb_load <= load_data;
    end

    assign mem_dest       = mem_q.dest;
    assign mem_reg_write  = mem_q.ctrl.reg_write;
    assign mem_mem_read   = mem_q.ctrl.mem_read;
    assign mem_alu_result = mem_q.alu_result; // forwarded into decode

    assign wb.reg_write = wb_reg_write;
    assign wb.dest      = wb_dest;
    assign wb.data      = wb_mem_to_reg ? wb_load : wb_alu;

endmodule

// ==== design/mips_pipe.sv ====
/* five-stage pipelined mips core
   fetch, decode, execute, memory and writeback with hazard control */
`timescale 1ns/1ps

module mips_pipe #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic                          SYS_clk,
    input  logic                          SYS_reset,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr,
    input  mips_pkg::word_t               prog_data,
    input  mips_pkg::reg_addr_t           dbg_reg_addr,
    output mips_pkg::word_t               dbg_reg_data
);
    import mips_pkg::*;

    word_t     instr;
    word_t     pc;
    word_t     target;
    logic      redirect;
    logic      stall;
    logic      fwd_rs;
    logic      fwd_rt;
    reg_addr_t rs;
    reg_addr_t rt;
    logic      uses_rs;
    logic      uses_rt;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    reg_addr_t ex_dest;
    logic      ex_reg_write;
    logic      ex_mem_read;
    reg_addr_t mem_dest;
    logic      mem_reg_write;
    logic      mem_mem_read;
    word_t     mem_alu_result;
    wb_t       wb;

    fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .SYS_clk, .SYS_reset, .prog_we, .prog_addr, .prog_data,
        .stall, .redirect, .target, .instr, .pc
    );

    decode_stage u_decode (
        .SYS_clk, .SYS_reset, .instr, .pc, .stall, .fwd_rs, .fwd_rt,
        .mem_alu_result, .wb, .dbg_reg_addr, .dbg_reg_data,
        .rs, .rt, .uses_rs, .uses_rt, .redirect, .target, .id_ex
    );

    hazard_unit u_hazard (
        .SYS_clk, .SYS_reset, .rs, .rt, .uses_rs, .uses_rt,
        .ex_dest, .ex_reg_write, .ex_mem_read,
        .mem_dest, .mem_reg_write, .mem_mem_read,
        .stall, .fwd_rs, .fwd_rt
    );

    execute_stage u_execute (
        .SYS_clk, .SYS_reset, .stall, .id_ex, .ex_mem,
        .ex_dest, .ex_reg_write, .ex_mem_read
    );

    mem_wb_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem_wb (
        .SYS_clk, .SYS_reset, .ex_mem, .mem_dest, .mem_reg_write,
        .mem_mem_read, .mem_alu_result, .wb
    );

endmodule

// ==== tests/tb_mips_encode.svh ====
/* mips instruction encoders and program loader for the pipeline testbench
   programs are built in a queue, then written through the load port under reset */
`ifndef TB_MIPS_ENCODE_SVH
`define TB_MIPS_ENCODE_SVH

function automatic word_t r_type(funct_e fn, int rd, int rs, int rt);
    return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic word_t i_type(opcode_e op, int rt, int rs, logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
endfunction

// target given as an instruction index in the program
function automatic word_t j_type(int idx);
    word_t addr;
    addr = RESET_PC + 32'(idx * 4);
    return {OP_J, addr[27:2]};
endfunction

task automatic emit(word_t w);
    prog.push_back(w);
endtask

// jump-to-self, the end of every program
task automatic emit_halt();
    prog.push_back(j_type(prog.size()));
endtask

// hold reset for at least hold cycles, one program word per cycle
task automatic load_program(int hold);
    @(negedge SYS_clk);
    SYS_reset = 1'b1;
    for (int i = 0; i < hold; i++)
    begin
        prog_we   = (i < prog.size());
        prog_addr = IADDR_W'(i);
        prog_data = (i < prog.size()) ? prog[i] : '0;
        @(negedge SYS_clk);
    end
    prog_we   = 1'b0;
    SYS_reset = 1'b0;  // core starts fetching at the next rising edge
endtask

`endif

// ==== tests/tb_mips_pipe.sv ====
/* testbench for the five-stage mips pipeline
   directed programs, results read back through the debug register port */
`timescale 1ns/1ps

module tb_mips_pipe;
    import mips_pkg::*;

    localparam int IMEM_WORDS   = 256;
    localparam int DMEM_WORDS   = 256;
    localparam int IADDR_W      = $clog2(IMEM_WORDS);
    localparam int RESET_CYCLES = 5;
    localparam int READ_MARGIN  = 40;  // debug reads after a program

    logic               SYS_clk = 1'b0;
    logic               SYS_reset;
    logic               prog_we;
    logic [IADDR_W-1:0] prog_addr;
    word_t              prog_data;
    reg_addr_t          dbg_reg_addr;
    word_t              dbg_reg_data;

    word_t prog[$];
    int    seed = 32'h3e305905;
    int    error_count = 0;
    int    test_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    cycle_count = 0;
    int    cycle_budget = 0;

    `include "tb_mips_encode.svh"

    mips_pipe #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) dut (
        .SYS_clk, .SYS_reset, .prog_we, .prog_addr, .prog_data,
        .dbg_reg_addr, .dbg_reg_data
    );

    always #4 SYS_clk = ~SYS_clk;

    always @(posedge SYS_clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_budget + 100)
        begin
            $display("timeout: the run went past %0d cycles", cycle_budget + 100);
            $display("Something failed");
            $finish;
        end
    end

    function automatic word_t sext16(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic word_t less_signed(word_t x, word_t y);
        return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
    endfunction

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            error_count = error_count + 1;
            test_errors = test_errors + 1;
        end
    endtask

    // called on a falling edge, returns one cycle later
    task automatic expect_reg(string name, int idx, word_t exp);
        dbg_reg_addr = 5'(idx);
        @(negedge SYS_clk);
        check_word($sformatf("%s r%0d", name, idx), exp, dbg_reg_data);
    endtask

    // no done signal, so each instruction gets four cycles
    task automatic run_program();
        int len;
        int hold;
        len  = prog.size();
        hold = (len > RESET_CYCLES) ? len : RESET_CYCLES;
        test_errors  = 0;
        cycle_budget = cycle_budget + hold + 4 * len + 10 + READ_MARGIN;
        load_program(hold);
        repeat (4 * len + 10) @(negedge SYS_clk);
    endtask

    task automatic end_test(string name);
        tests_run = tests_run + 1;
        if (test_errors == 0)
            $display("%-16s passed", name);
        else
        begin
            $display("%-16s failed with %0d errors", name, test_errors);
            tests_failed = tests_failed + 1;
        end
    endtask

    task automatic reset_clears_regs();
        prog.delete();
        emit(i_type(OP_ADDI, 0, 0, 16'h1234)); // $0 must ignore the write
        emit_halt();
        run_program();
        for (int i = 0; i < 32; i++)
            expect_reg("reset_state", i, 32'd0);
        end_test("reset_state");
    endtask

    task automatic alu_ops_random();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        word_t       wa;
        word_t       wb;
        a  = 16'($random(seed));
        b  = 16'($random(seed));
        c  = 16'($random(seed));
        wa = sext16(a);
        wb = sext16(b);
        prog.delete();
        emit(i_type(OP_ADDI, 1, 0, a));
        emit(i_type(OP_ADDI, 2, 0, b));
        emit(r_type(FN_ADD, 3, 1, 2));
        emit(r_type(FN_SUB, 4, 1, 2));
        emit(r_type(FN_AND, 5, 1, 2));
        emit(r_type(FN_OR, 6, 1, 2));
        emit(r_type(FN_SLT, 7, 1, 2));
        emit(r_type(FN_SLT, 8, 2, 1));
        emit(i_type(OP_ADDI, 9, 1, c));
        emit_halt();
        run_program();
        expect_reg("alu_ops", 1, wa);
        expect_reg("alu_ops", 2, wb);
        expect_reg("alu_ops", 3, wa + wb);
        expect_reg("alu_ops", 4, wa - wb);
        expect_reg("alu_ops", 5, wa & wb);
        expect_reg("alu_ops", 6, wa | wb);
        expect_reg("alu_ops", 7, less_signed(wa, wb));
        expect_reg("alu_ops", 8, less_signed(wb, wa));
        expect_reg("alu_ops", 9, wa + sext16(c));
        end_test("alu_ops");
    endtask

    task automatic dependent_chain();
        logic [15:0] a;
        logic [15:0] c;
        logic [15:0] d;
        word_t       w [11];
        a = 16'($random(seed));
        c = 16'($random(seed));
        d = 16'($random(seed));
        prog.delete();
        emit(i_type(OP_ADDI, 1, 0, a));
        emit(r_type(FN_ADD, 2, 1, 1));     // each one needs the one before
        emit(r_type(FN_SUB, 3, 2, 1));
        emit(r_type(FN_OR, 4, 3, 2));
        emit(i_type(OP_ADDI, 5, 4, c));
        emit(r_type(FN_AND, 6, 5, 4));
        emit(r_type(FN_SLT, 7, 6, 5));
        emit(i_type(OP_ADDI, 8, 0, d));
        emit(i_type(OP_ADDI, 11, 0, 16'd1));
        emit(r_type(FN_ADD, 10, 8, 8));    // r8 one slot back, in memory
        emit_halt();
        run_program();
        w[1]  = sext16(a);
        w[2]  = w[1] + w[1];
        w[3]  = w[2] - w[1];
        w[4]  = w[3] | w[2];
        w[5]  = w[4] + sext16(c);
        w[6]  = w[5] & w[4];
        w[7]  = less_signed(w[6], w[5]);
        w[8]  = sext16(d);
        w[10] = w[8] + w[8];
        for (int i = 1; i <= 8; i++)
            expect_reg("dep_chain", i, w[i]);
        expect_reg("dep_chain", 10, w[10]);
        expect_reg("dep_chain", 11, 32'd1);
        end_test("dep_chain");
    endtask

    task automatic store_load_use();
        logic [15:0] v;
        logic [15:0] x;
        v = 16'($random(seed));
        x = 16'($random(seed));
        prog.delete();
        emit(i_type(OP_ADDI, 1, 0, 16'h0040)); // base address
        emit(i_type(OP_ADDI, 2, 0, v));
        emit(i_type(OP_ADDI, 5, 0, x));
        emit(i_type(OP_SW, 2, 1, 16'd4));
        emit(i_type(OP_LW, 3, 1, 16'd4));
        emit(r_type(FN_ADD, 4, 3, 5));         // load-use right behind lw
        emit(i_type(OP_LW, 6, 1, 16'd4));
        emit(i_type(OP_ADDI, 8, 0, 16'd1));
        emit(r_type(FN_ADD, 7, 6, 6));         // load one stage ahead
        emit_halt();
        run_program();
        expect_reg("load_use", 3, sext16(v));
        expect_reg("load_use", 4, sext16(v) + sext16(x));
        expect_reg("load_use", 6, sext16(v));
        expect_reg("load_use", 7, sext16(v) + sext16(v));
        end_test("load_use");
    endtask

    task automatic branch_outcomes();
        logic [15:0] a;
        logic [15:0] b;
        a = 16'($random(seed));
        b = a ^ 16'h0001;                      // always differs from a
        prog.delete();
        emit(i_type(OP_ADDI, 1, 0, a));
        emit(i_type(OP_ADDI, 2, 0, a));
        emit(i_type(OP_BEQ, 2, 1, 16'd1));     // taken, r2 just produced
        emit(i_type(OP_ADDI, 10, 0, 16'd1));
        emit(i_type(OP_ADDI, 3, 0, b));
        emit(i_type(OP_BNE, 3, 1, 16'd1));     // taken
        emit(i_type(OP_ADDI, 11, 0, 16'd1));
        emit(i_type(OP_BEQ, 3, 1, 16'd1));     // falls through
        emit(i_type(OP_ADDI, 12, 0, 16'd5));
        emit(i_type(OP_BNE, 2, 1, 16'd1));     // falls through
        emit(i_type(OP_ADDI, 13, 0, 16'd7));
        emit_halt();
        run_program();
        expect_reg("branches", 1, sext16(a));
        expect_reg("branches", 3, sext16(b));
        expect_reg("branches", 10, 32'd0);
        expect_reg("branches", 11, 32'd0);
        expect_reg("branches", 12, 32'd5);
        expect_reg("branches", 13, 32'd7);
        end_test("branches");
    endtask

    task automatic jump_skips();
        logic [15:0] a;
        logic [15:0] c;
        a = 16'($random(seed));
        c = 16'($random(seed));
        prog.delete();
        emit(i_type(OP_ADDI, 1, 0, a));
        emit(j_type(4));
        emit(i_type(OP_ADDI, 10, 0, 16'd1));
        emit(i_type(OP_ADDI, 11, 0, 16'd1));
        emit(i_type(OP_ADDI, 2, 1, c));        // jump target
        emit(r_type(FN_ADD, 3, 2, 1));
        emit_halt();
        run_program();
        expect_reg("jump", 10, 32'd0);
        expect_reg("jump", 11, 32'd0);
        expect_reg("jump", 2, sext16(a) + sext16(c));
        expect_reg("jump", 3, sext16(a) + sext16(c) + sext16(a));
        end_test("jump");
    endtask

    initial
    begin
        SYS_reset    = 1'b1;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        dbg_reg_addr = '0;
        alu_ops_random();
        dependent_chain();
        reset_clears_regs(); // registers hold the chain results going in
        store_load_use();
        branch_outcomes();
        jump_skips();
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== mips_pipe.f ====
+incdir+tests
design/mips_pkg.sv
design/fetch_stage.sv
design/hazard_unit.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/mips_pipe.sv
tests/tb_mips_pipe.sv

// ==== Makefile ====
TOP = tb_mips_pipe

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f mips_pipe.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/1ps -f mips_pipe.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
